// ==== src/rv_isa_pkg.sv ====
//##########################################################################
// rv32i isa definitions for the integer alu core
// widths, opcode and funct fields, alu operation codes
//##########################################################################
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  alu_op_t;

    localparam addr_t reset_pc = 32'h0000_0000;

    // major opcodes handled by the core
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // base and alternate (sub, sra) funct7
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_sll  = 4'd2;
    localparam alu_op_t alu_slt  = 4'd3;
    localparam alu_op_t alu_sltu = 4'd4;
    localparam alu_op_t alu_xor  = 4'd5;
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_or   = 4'd8;
    localparam alu_op_t alu_and  = 4'd9;
    // operand b straight through, used by lui
    localparam alu_op_t alu_pass = 4'd10;

endpackage

// ==== src/cpu_pipe_pkg.sv ====
//##########################################################################
// pipeline items passed between the core stages
// fetch, decode, issue and commit records plus memory controller states
//##########################################################################
package cpu_pipe_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t inst;
        addr_t pc;
    } fetch_item_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        addr_t    pc;
        logic     use_imm;
        logic     use_pc;
        logic     wr;
    } decode_item_t;

    // operands already selected, ready for the alu
    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        logic     wr;
    } issue_item_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } commit_t;

    typedef enum logic [1:0] {
        idle,
        read,
        finish
    } mc_state_t;

endpackage

// ==== src/memctrl.sv ====
//##########################################################################
// memory controller, four byte reads per instruction word
//##########################################################################
`timescale 1ns/100ps

module memctrl (
    input  logic              clk_in,
    input  logic              rst_n,
    input  logic              rdy_in,
    input  logic              fetch_req,
    input  rv_isa_pkg::addr_t fetch_pc,
    output logic              fetch_done,
    output rv_isa_pkg::word_t fetch_inst,
    output rv_isa_pkg::addr_t mem_a,
    input  rv_isa_pkg::byte_t mem_din
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    mc_state_t  state;
    addr_t      base;
    logic [1:0] cnt;
    logic [1:0] byte_sel;

    // byte 0 goes out in the request cycle itself
    assign mem_a = (state == idle) ? fetch_pc : base + addr_t'(cnt);

    // data arriving now belongs to last cycle's address
    assign byte_sel = cnt - 2'd1;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            cnt        <= 2'd0;
            fetch_done <= 1'b0;
        end else if (rdy_in) begin
            fetch_done <= 1'b0;
            case (state)
                idle: begin
                    if (fetch_req) begin
                        state <= read;
                        cnt   <= 2'd1;
                    end
                end
                read: begin
                    // cnt wraps to 0 so finish takes byte 3
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'd3) begin
                        state <= finish;
                    end
                end
                finish: begin
                    state      <= idle;
                    fetch_done <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

    // little endian assembly, byte n lands at bits 8n
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == idle && fetch_req) begin
                base <= fetch_pc;
            end
            if (state != idle) begin
                fetch_inst[8*byte_sel +: 8] <= mem_din;
            end
        end
    end

endmodule

// ==== src/fetcher.sv ====
//##########################################################################
// instruction fetcher, one outstanding word request at a time
//##########################################################################
`timescale 1ns/100ps

module fetcher (
    input  logic                      clk_in,
    input  logic                      rst_n,
    input  logic                      rdy_in,
    output logic                      fetch_req,
    output rv_isa_pkg::addr_t         fetch_pc,
    input  logic                      fetch_done,
    input  rv_isa_pkg::word_t         fetch_inst,
    output cpu_pipe_pkg::fetch_item_t fetch_out
);
    import rv_isa_pkg::*;

    addr_t pc;
    logic  started;

    assign fetch_pc = pc;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= reset_pc;
            started   <= 1'b0;
            fetch_req <= 1'b0;
            fetch_out <= '0;
        end else if (rdy_in) begin
            started <= 1'b1;
            // kick off once after reset, then chain on each returned word
            fetch_req       <= !started || fetch_done;
            fetch_out.valid <= fetch_done;
            if (fetch_done) begin
                pc             <= pc + 32'd4;
                fetch_out.inst <= fetch_inst;
                fetch_out.pc   <= pc;
            end
        end
    end

endmodule

// ==== src/decoder.sv ====
//##########################################################################
// instruction decoder for op, op-imm, lui and auipc
//##########################################################################
`timescale 1ns/100ps

module decoder (
    input  logic                       clk_in,
    input  logic                       rst_n,
    input  logic                       rdy_in,
    input  cpu_pipe_pkg::fetch_item_t  fetch_in,
    output cpu_pipe_pkg::decode_item_t dec_out
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    word_t        imm_i;
    word_t        imm_u;
    alu_op_t      f3_op;
    logic         supported;
    decode_item_t dec_d;

    assign opcode = fetch_in.inst[6:0];
    assign funct3 = fetch_in.inst[14:12];
    assign funct7 = fetch_in.inst[31:25];
    assign imm_i  = {{20{fetch_in.inst[31]}}, fetch_in.inst[31:20]};
    assign imm_u  = {fetch_in.inst[31:12], 12'h000};

    // funct3 mapping common to op and op-imm
    always_comb begin
        case (funct3)
            f3_add_sub: f3_op = alu_add;
            f3_sll:     f3_op = alu_sll;
            f3_slt:     f3_op = alu_slt;
            f3_sltu:    f3_op = alu_sltu;
            f3_xor:     f3_op = alu_xor;
            f3_srl_sra: f3_op = funct7[5] ? alu_sra : alu_srl;
            f3_or:      f3_op = alu_or;
            f3_and:     f3_op = alu_and;
        endcase
    end

    always_comb begin
        dec_d.op  = f3_op;
        supported = 1'b0;
        case (opcode)
            opc_op: begin
                if (funct3 == f3_add_sub && funct7[5]) begin
                    dec_d.op = alu_sub;
                end
                supported = (funct7 == f7_base) || (funct7 == f7_alt &&
                            (funct3 == f3_add_sub || funct3 == f3_srl_sra));
            end
            opc_op_imm: begin
                // shift immediates keep funct7 in the upper imm bits
                if (funct3 == f3_sll) begin
                    supported = (funct7 == f7_base);
                end else if (funct3 == f3_srl_sra) begin
                    supported = (funct7 == f7_base) || (funct7 == f7_alt);
                end else begin
                    supported = 1'b1;
                end
            end
            opc_lui: begin
                dec_d.op  = alu_pass;
                supported = 1'b1;
            end
            opc_auipc: begin
                dec_d.op  = alu_add;
                supported = 1'b1;
            end
            default: supported = 1'b0;
        endcase

        dec_d.valid   = fetch_in.valid;
        dec_d.rs1     = fetch_in.inst[19:15];
        dec_d.rs2     = fetch_in.inst[24:20];
        dec_d.rd      = fetch_in.inst[11:7];
        dec_d.imm     = (opcode == opc_lui || opcode == opc_auipc) ? imm_u : imm_i;
        dec_d.pc      = fetch_in.pc;
        dec_d.use_imm = (opcode != opc_op);
        dec_d.use_pc  = (opcode == opc_auipc);
        // unsupported words still flow down, they just never write
        dec_d.wr      = supported && (dec_d.rd != 5'd0);
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dec_out <= '0;
        end else if (rdy_in) begin
            dec_out <= dec_d;
        end
    end

endmodule

// ==== src/regfile.sv ====
//##########################################################################
// register file, operand read and commit write back
//##########################################################################
`timescale 1ns/100ps

module regfile (
    input  logic                       clk_in,
    input  logic                       rst_n,
    input  logic                       rdy_in,
    input  cpu_pipe_pkg::decode_item_t dec_in,
    output cpu_pipe_pkg::issue_item_t  iss_out,
    input  cpu_pipe_pkg::commit_t      commit_in
);
    import rv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];
    word_t rs1_val;
    word_t rs2_val;

    assign rs1_val = (dec_in.rs1 == 5'd0) ? '0 : regs[dec_in.rs1];
    assign rs2_val = (dec_in.rs2 == 5'd0) ? '0 : regs[dec_in.rs2];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            iss_out <= '0;
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in) begin
            iss_out.valid <= dec_in.valid;
            iss_out.op    <= dec_in.op;
            iss_out.rd    <= dec_in.rd;
            // auipc takes the pc, immediate forms take imm
            iss_out.a     <= dec_in.use_pc ? dec_in.pc : rs1_val;
            iss_out.b     <= dec_in.use_imm ? dec_in.imm : rs2_val;
            iss_out.wr    <= dec_in.wr;
            if (commit_in.valid && commit_in.rd != 5'd0) begin
                regs[commit_in.rd] <= commit_in.data;
            end
        end
    end

endmodule

// ==== src/execute.sv ====
//##########################################################################
// execute stage, alu and commit record
//##########################################################################
`timescale 1ns/100ps

module execute (
    input  logic                      clk_in,
    input  logic                      rst_n,
    input  logic                      rdy_in,
    input  cpu_pipe_pkg::issue_item_t iss_in,
    output cpu_pipe_pkg::commit_t     commit
);
    import rv_isa_pkg::*;

    word_t      result;
    logic [4:0] shamt;

    assign shamt = iss_in.b[4:0];

    always_comb begin
        case (iss_in.op)
            alu_add:  result = iss_in.a + iss_in.b;
            alu_sub:  result = iss_in.a - iss_in.b;
            alu_sll:  result = iss_in.a << shamt;
            alu_slt:  result = {31'd0, $signed(iss_in.a) < $signed(iss_in.b)};
            alu_sltu: result = {31'd0, iss_in.a < iss_in.b};
            alu_xor:  result = iss_in.a ^ iss_in.b;
            alu_srl:  result = iss_in.a >> shamt;
            alu_sra:  result = $signed(iss_in.a) >>> shamt;
            alu_or:   result = iss_in.a | iss_in.b;
            alu_and:  result = iss_in.a & iss_in.b;
            alu_pass: result = iss_in.b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            commit <= '0;
        end else if (rdy_in) begin
            // only real register writes retire
            commit.valid <= iss_in.valid && iss_in.wr;
            commit.rd    <= iss_in.rd;
            commit.data  <= result;
        end
    end

endmodule

// ==== src/cpu.sv ====
//##########################################################################
// rv32i integer alu core, top level of the stage pipeline
//##########################################################################
`timescale 1ns/100ps

module cpu (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  rdy_in,
    input  rv_isa_pkg::byte_t     mem_din,
    output rv_isa_pkg::addr_t     mem_a,
    output cpu_pipe_pkg::commit_t commit
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic         fetch_req;
    logic         fetch_done;
    addr_t        fetch_pc;
    word_t        fetch_inst;
    fetch_item_t  fetch_item;
    decode_item_t dec_item;
    issue_item_t  iss_item;

    memctrl memctrl (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .fetch_done (fetch_done),
        .fetch_inst (fetch_inst),
        .mem_a      (mem_a),
        .mem_din    (mem_din)
    );

    fetcher fetcher (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .fetch_done (fetch_done),
        .fetch_inst (fetch_inst),
        .fetch_out  (fetch_item)
    );

    decoder decoder (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rdy_in   (rdy_in),
        .fetch_in (fetch_item),
        .dec_out  (dec_item)
    );

    // commit feeds back here for write back
    regfile regfile (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .rdy_in    (rdy_in),
        .dec_in    (dec_item),
        .iss_out   (iss_item),
        .commit_in (commit)
    );

    execute execute (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .rdy_in (rdy_in),
        .iss_in (iss_item),
        .commit (commit)
    );

endmodule

// ==== verif/tb_cpu.sv ====
//##########################################################################
// testbench for the rv32i integer alu core
// random program, in-order reference model and commit checks
//##########################################################################
`timescale 1ns/100ps

module tb_cpu;
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int n_inst     = 48;
    localparam int mem_bytes  = 256;
    localparam int max_cycles = 3000;

    logic     clk_in;
    logic     rst_n;
    logic     rdy_in;
    byte_t    mem_din;
    addr_t    mem_a;
    commit_t  commit;

    byte_t    mem [0:mem_bytes-1];
    word_t    model_regs [0:31];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    addr_t    addr_prev;
    word_t    lcg_state;
    logic     freeze_en;
    int       value_errs;
    int       other_errs;
    int       commit_cnt;
    int       model_cnt;

    cpu u_dut (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rdy_in  (rdy_in),
        .mem_din (mem_din),
        .mem_a   (mem_a),
        .commit  (commit)
    );

    always #20 clk_in = ~clk_in;

    // two lcg steps, upper halves only
    function word_t rand_word();
        word_t hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    // bytes past the end read as zero words
    function byte_t read_mem(input addr_t a);
        if (a < addr_t'(mem_bytes)) begin
            return mem[a[7:0]];
        end
        return 8'h00;
    endfunction

    // opx: add sub sll slt sltu xor srl sra or and
    function word_t alu_ref(input int opx, input word_t a, input word_t b);
        word_t r;
        case (opx)
            0: r = a + b;
            1: r = a - b;
            2: r = a << b[4:0];
            3: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: r = (a < b) ? 32'd1 : 32'd0;
            5: r = a ^ b;
            6: r = a >> b[4:0];
            7: r = word_t'($signed(a) >>> b[4:0]);
            8: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function logic [2:0] funct3_of(input int opx);
        case (opx)
            0, 1: return 3'd0;
            2: return 3'd1;
            3: return 3'd2;
            4: return 3'd3;
            5: return 3'd4;
            6, 7: return 3'd5;
            8: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    task check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one clock, then drive memory data and rdy
    task step();
        @(posedge clk_in);
        #2;
        if (rdy_in) begin
            mem_din = read_mem(addr_prev);
        end
        addr_prev = mem_a;
        rdy_in = freeze_en ? (rand_word() % 32'd4 != 32'd0) : 1'b1;
    endtask

    task build_program();
        word_t      r;
        word_t      k;
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      val;
        int         kind;
        int         opx;
        logic [6:0] f7;
        logic [11:0] imm12;
        logic       wr;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   prev_rd;
        exp_rd.delete();
        exp_data.delete();
        model_cnt = 0;
        prev_rd = 5'd0;
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = 8'h00;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < n_inst; i++) begin
            r = rand_word();
            k = rand_word();
            rd = {2'b00, r[2:0]};
            // a quarter of reads chain on the previous rd
            rs1 = (r[5:4] == 2'd0) ? prev_rd : {2'b00, r[8:6]};
            rs2 = {2'b00, r[11:9]};
            imm12 = r[23:12];
            kind = int'(k[31:16] % 16'd21);
            wr = 1'b1;
            val = '0;
            if (i == 0) begin
                kind = 19;
                rd = rd | 5'd1;
            end else if (k % 32'd10 == 32'd0) begin
                kind = 21;
            end
            if (kind < 9) begin
                opx = (kind >= 1) ? kind + 1 : kind;
                if (opx == 2 || opx == 6 || opx == 7) begin
                    imm12 = {(opx == 7) ? 7'b0100000 : 7'b0000000, r[16:12]};
                end
                a = model_regs[rs1];
                b = {{20{imm12[11]}}, imm12};
                val = alu_ref(opx, a, b);
                inst = {imm12, rs1, funct3_of(opx), rd, 7'b0010011};
            end else if (kind < 19) begin
                opx = kind - 9;
                f7 = (opx == 1 || opx == 7) ? 7'b0100000 : 7'b0000000;
                val = alu_ref(opx, model_regs[rs1], model_regs[rs2]);
                inst = {f7, rs2, rs1, funct3_of(opx), rd, 7'b0110011};
            end else if (kind == 19) begin
                val = {r[31:12], 12'h000};
                inst = {r[31:12], rd, 7'b0110111};
            end else if (kind == 20) begin
                val = addr_t'(4 * i) + {r[31:12], 12'h000};
                inst = {r[31:12], rd, 7'b0010111};
            end else begin
                wr = 1'b0;
                case (k[5:4])
                    2'd0: inst = {r[31:7], 7'b0000011};
                    2'd1: inst = {r[31:7], 7'b0100011};
                    2'd2: inst = {r[31:7], 7'b1100011};
                    default: inst = {7'b0000001, r[24:7], 7'b0110011};
                endcase
            end
            if (wr && rd != 5'd0) begin
                model_regs[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
                model_cnt++;
            end
            prev_rd = rd;
            for (int j = 0; j < 4; j++) begin
                mem[4 * i + j] = inst[8 * j +: 8];
            end
        end
    endtask

    task run_program(input logic freeze);
        int cycles;
        freeze_en = 1'b0;
        rst_n = 1'b0;
        repeat (3) step();
        build_program();
        commit_cnt = 0;
        rst_n = 1'b1;
        freeze_en = freeze;
        cycles = 0;
        while (exp_rd.size() != 0 && cycles < max_cycles) begin
            step();
            cycles++;
        end
        if (exp_rd.size() != 0) begin
            other_errs++;
            $display("timeout: %0d expected commits still missing after %0d cycles",
                     exp_rd.size(), max_cycles);
        end
        // trailing zero words must stay silent
        repeat (60) step();
        if (commit_cnt != model_cnt) begin
            other_errs++;
            $display("commit count %0d differs from the model count %0d", commit_cnt, model_cnt);
        end
    endtask

    // a commit counts at the next rising edge when rdy is high
    always @(negedge clk_in) begin
        if (rst_n && rdy_in && commit.valid) begin
            commit_cnt++;
            if (exp_rd.size() == 0) begin
                other_errs++;
                $display("commit to x%0d with data 0x%h arrived when none was expected",
                         commit.rd, commit.data);
            end else begin
                check_reg_idx("commit.rd", commit.rd, exp_rd.pop_front());
                check_word("commit.data", commit.data, exp_data.pop_front());
            end
        end
    end

    initial begin
        clk_in = 1'b0;
        rst_n = 1'b0;
        rdy_in = 1'b1;
        mem_din = 8'h00;
        addr_prev = '0;
        freeze_en = 1'b0;
        lcg_state = 32'd94;
        value_errs = 0;
        other_errs = 0;
        commit_cnt = 0;
        model_cnt = 0;
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = 8'h00;
        end
        // free running first, then with random stalls
        run_program(1'b0);
        run_program(1'b1);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/rv_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/memctrl.sv
src/fetcher.sv
src/decoder.sv
src/regfile.sv
src/execute.sv
src/cpu.sv
verif/tb_cpu.sv

// ==== Makefile ====
TOP = tb_cpu

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
